/* hw/core_pkg.sv */
package core_pkg;

  // data and address width of the RV32 core
  localparam int xlen = 32;
  // register index width, 32 architectural registers
  localparam int reg_addr_w = 5;

  // register data, pc and immediates
  typedef logic [xlen-1:0] word_t;
  // one RV32 instruction
  typedef logic [31:0] insn_t;
  // register index
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // major opcodes in bits [6:0]
  // other values are legal encodings, decoded as no-ops
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_system  = 7'b1110011
  } opcode_e;

  // decoded operation carried down the pipe
  // alu_nop must stay zero, it is the cleared value
  typedef enum logic [2:0] {
    alu_nop   = 3'd0,
    alu_lui   = 3'd1,
    alu_addi  = 3'd2,
    alu_slti  = 3'd3,
    alu_add   = 3'd4,
    alu_ecall = 3'd5
  } alu_op_e;

  // what the writeback stage holds in a given cycle
  typedef enum logic [1:0] {
    cycle_invalid  = 2'd0,
    cycle_reset    = 2'd1,
    cycle_no_stall = 2'd2
  } cycle_status_e;

  // decode stage register
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
  } fetch_out_t;

  // execute stage register
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    alu_op_e       alu_op;
    reg_idx_t      rd;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    // values as read in decode, before forwarding
    word_t         rs1_data;
    word_t         rs2_data;
    // I-type sign extended or U-type shifted
    word_t         imm;
    // set only for a writing op with nonzero rd
    logic          we;
  } issue_t;

  // memory and writeback stage registers
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    reg_idx_t      rd;
    logic          we;
    word_t         data;
    logic          halt;
  } result_t;

  // empty slot left behind by reset
  localparam result_t result_reset = '{
    pc:     '0,
    insn:   '0,
    status: cycle_reset,
    rd:     '0,
    we:     1'b0,
    data:   '0,
    halt:   1'b0
  };

endpackage

/* hw/fetch_stage.sv */
module fetch_stage #(
  parameter core_pkg::word_t reset_pc = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  output core_pkg::word_t      pc,
  input  core_pkg::insn_t      insn,
  output core_pkg::fetch_out_t fetch_out
);

  // program counter
  // sits at reset_pc through reset, then steps one word per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc + core_pkg::word_t'(4);
    end
  end

  // fetch to decode register
  // insn arrives combinationally for the pc driven this cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_out.pc     <= '0;
      fetch_out.insn   <= '0;
      fetch_out.status <= core_pkg::cycle_reset;
    end else begin
      fetch_out.pc     <= pc;
      fetch_out.insn   <= insn;
      // no stall sources, every fetched slot is valid
      fetch_out.status <= core_pkg::cycle_no_stall;
    end
  end

endmodule

/* hw/decode_stage.sv */
module decode_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  core_pkg::fetch_out_t fetch_out,
  output core_pkg::reg_idx_t   rs1,
  output core_pkg::reg_idx_t   rs2,
  input  core_pkg::word_t      rs1_data,
  input  core_pkg::word_t      rs2_data,
  output core_pkg::issue_t     issue
);

  core_pkg::opcode_e  opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  core_pkg::reg_idx_t rd;
  core_pkg::alu_op_e  alu_op;
  core_pkg::word_t    imm;
  logic               we;

  // R-type field split
  assign opcode = core_pkg::opcode_e'(fetch_out.insn[6:0]);
  assign rd     = fetch_out.insn[11:7];
  assign funct3 = fetch_out.insn[14:12];
  assign rs1    = fetch_out.insn[19:15];
  assign rs2    = fetch_out.insn[24:20];
  assign funct7 = fetch_out.insn[31:25];

  // opcode plus funct fields to alu op
  // anything not matched falls to a no-op
  always_comb begin
    alu_op = core_pkg::alu_nop;
    case (opcode)
      core_pkg::op_lui: begin
        alu_op = core_pkg::alu_lui;
      end
      core_pkg::op_reg_imm: begin
        if (funct3 == 3'b000) begin
          alu_op = core_pkg::alu_addi;
        end else if (funct3 == 3'b010) begin
          alu_op = core_pkg::alu_slti;
        end
      end
      core_pkg::op_reg_reg: begin
        // funct7 zero separates add from sub and mul
        if (funct3 == 3'b000 && funct7 == 7'd0) begin
          alu_op = core_pkg::alu_add;
        end
      end
      core_pkg::op_system: begin
        // ecall is all zero above the opcode
        if (fetch_out.insn[31:7] == 25'd0) begin
          alu_op = core_pkg::alu_ecall;
        end
      end
      default: begin
        alu_op = core_pkg::alu_nop;
      end
    endcase
  end

  // U-type for lui, sign extended I-type otherwise
  always_comb begin
    if (alu_op == core_pkg::alu_lui) begin
      imm = {fetch_out.insn[31:12], 12'd0};
    end else begin
      imm = {{20{fetch_out.insn[31]}}, fetch_out.insn[31:20]};
    end
  end

  // x0 writes dropped here, later stages trust the flag
  assign we = (alu_op inside {core_pkg::alu_lui, core_pkg::alu_addi,
                              core_pkg::alu_slti, core_pkg::alu_add})
              && (rd != '0);

  // decode to execute register
  always_ff @(posedge clk) begin
    if (rst) begin
      issue        <= '0;
      issue.status <= core_pkg::cycle_reset;
    end else begin
      issue.pc       <= fetch_out.pc;
      issue.insn     <= fetch_out.insn;
      issue.status   <= fetch_out.status;
      issue.alu_op   <= alu_op;
      issue.rd       <= rd;
      issue.rs1      <= rs1;
      issue.rs2      <= rs2;
      // read data already includes same-cycle writeback
      issue.rs1_data <= rs1_data;
      issue.rs2_data <= rs2_data;
      issue.imm      <= imm;
      issue.we       <= we;
    end
  end

endmodule

/* hw/reg_file.sv */
module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  output core_pkg::word_t    rs1_data,
  output core_pkg::word_t    rs2_data,
  input  core_pkg::result_t  wb
);

  core_pkg::word_t regs [32];

  // one read port
  // x0 is zero, a write this cycle wins over the stored word
  function automatic core_pkg::word_t read_port(input core_pkg::reg_idx_t idx);
    core_pkg::word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (wb.we && wb.rd == idx) begin
      val = wb.data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  // write port from writeback
  // rd zero never arrives with we set
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we) begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

/* hw/execute_stage.sv */
module execute_stage (
  input  logic              clk,
  input  logic              rst,
  input  core_pkg::issue_t  issue,
  input  core_pkg::result_t mem_fwd,
  input  core_pkg::result_t wb_fwd,
  output core_pkg::result_t mem_out
);

  core_pkg::word_t op_a;
  core_pkg::word_t op_b;
  core_pkg::word_t addend;
  core_pkg::word_t sum;
  logic            less;
  core_pkg::word_t result;

  // operand bypass
  // memory stage is younger so it wins over writeback
  function automatic core_pkg::word_t fwd_operand(
    input core_pkg::reg_idx_t idx,
    input core_pkg::word_t    rf_val,
    input core_pkg::result_t  mem_src,
    input core_pkg::result_t  wb_src
  );
    core_pkg::word_t val;
    if (mem_src.we && mem_src.rd == idx) begin
      val = mem_src.data;
    end else if (wb_src.we && wb_src.rd == idx) begin
      val = wb_src.data;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  always_comb begin
    op_a = fwd_operand(issue.rs1, issue.rs1_data, mem_fwd, wb_fwd);
    op_b = fwd_operand(issue.rs2, issue.rs2_data, mem_fwd, wb_fwd);
  end

  // one adder shared by addi and add
  assign addend = (issue.alu_op == core_pkg::alu_add) ? op_b : issue.imm;
  assign sum    = op_a + addend;

  // slti compares signed against the immediate
  assign less = $signed(op_a) < $signed(issue.imm);

  always_comb begin
    case (issue.alu_op)
      core_pkg::alu_lui: begin
        result = issue.imm;
      end
      core_pkg::alu_addi, core_pkg::alu_add: begin
        result = sum;
      end
      core_pkg::alu_slti: begin
        result = {{(core_pkg::xlen - 1){1'b0}}, less};
      end
      default: begin
        // nop and ecall write nothing
        result = '0;
      end
    endcase
  end

  // execute to memory register
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_out <= core_pkg::result_reset;
    end else begin
      mem_out.pc     <= issue.pc;
      mem_out.insn   <= issue.insn;
      mem_out.status <= issue.status;
      mem_out.rd     <= issue.rd;
      mem_out.we     <= issue.we;
      mem_out.data   <= result;
      // halt rides along until writeback
      mem_out.halt   <= (issue.alu_op == core_pkg::alu_ecall);
    end
  end

endmodule

/* hw/retire_stage.sv */
module retire_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  core_pkg::result_t       mem_in,
  output core_pkg::result_t       mem_fwd,
  output core_pkg::result_t       wb,
  output logic                    halt,
  output core_pkg::word_t         trace_pc,
  output core_pkg::insn_t         trace_insn,
  output core_pkg::cycle_status_e trace_status,
  output logic                    trace_we,
  output core_pkg::reg_idx_t      trace_rd,
  output core_pkg::word_t         trace_data
);

  // writeback register
  // memory stage register is mem_out in execute, no loads or stores
  always_ff @(posedge clk) begin
    if (rst) begin
      wb <= core_pkg::result_reset;
    end else begin
      wb <= mem_in;
    end
  end

  // memory stage value straight back for bypass
  assign mem_fwd = mem_in;

  // ecall sitting in writeback
  assign halt = wb.halt;

  // writeback trace
  assign trace_pc     = wb.pc;
  assign trace_insn   = wb.insn;
  assign trace_status = wb.status;
  // same write the register file takes this cycle
  assign trace_we     = wb.we;
  assign trace_rd     = wb.rd;
  assign trace_data   = wb.data;

endmodule

/* hw/riscv_core.sv */
module riscv_core #(
  parameter core_pkg::word_t reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  output core_pkg::word_t         pc,
  input  core_pkg::insn_t         insn,
  output logic                    halt,
  output core_pkg::word_t         trace_pc,
  output core_pkg::insn_t         trace_insn,
  output core_pkg::cycle_status_e trace_status,
  output logic                    trace_we,
  output core_pkg::reg_idx_t      trace_rd,
  output core_pkg::word_t         trace_data
);

  // fetch to decode
  core_pkg::fetch_out_t fetch_out;
  // register file read ports
  core_pkg::reg_idx_t   rs1;
  core_pkg::reg_idx_t   rs2;
  core_pkg::word_t      rs1_data;
  core_pkg::word_t      rs2_data;
  // decode to execute
  core_pkg::issue_t     issue;
  // execute result into the memory register
  core_pkg::result_t    mem_out;
  // memory and writeback registers, fed back for bypass
  core_pkg::result_t    mem_fwd;
  core_pkg::result_t    wb;

  fetch_stage #(
    .reset_pc (reset_pc)
  ) i_fetch (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .insn      (insn),
    .fetch_out (fetch_out)
  );

  decode_stage i_decode (
    .clk       (clk),
    .rst       (rst),
    .fetch_out (fetch_out),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .issue     (issue)
  );

  // written from writeback, read in decode
  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  execute_stage i_execute (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .mem_fwd (mem_fwd),
    .wb_fwd  (wb),
    .mem_out (mem_out)
  );

  retire_stage i_retire (
    .clk          (clk),
    .rst          (rst),
    .mem_in       (mem_out),
    .mem_fwd      (mem_fwd),
    .wb           (wb),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_we     (trace_we),
    .trace_rd     (trace_rd),
    .trace_data   (trace_data)
  );

endmodule

/* tests/core_model.svh */
// encoders for the formats the core executes
function automatic core_pkg::insn_t enc_lui(input core_pkg::reg_idx_t rd, input logic [19:0] imm);
  return {imm, rd, core_pkg::op_lui};
endfunction

// addi with funct3 000, slti with funct3 010
function automatic core_pkg::insn_t enc_imm(input logic [2:0] funct3, input core_pkg::reg_idx_t rd,
                                            input core_pkg::reg_idx_t rs1, input logic [11:0] imm);
  return {imm, rs1, funct3, rd, core_pkg::op_reg_imm};
endfunction

function automatic core_pkg::insn_t enc_add(input core_pkg::reg_idx_t rd,
                                            input core_pkg::reg_idx_t rs1,
                                            input core_pkg::reg_idx_t rs2);
  return {7'd0, rs2, rs1, 3'b000, rd, core_pkg::op_reg_reg};
endfunction

function automatic core_pkg::insn_t enc_ecall();
  return {25'd0, core_pkg::op_system};
endfunction

// sequential reference, one instruction at a time, no pipeline
// fills exp_we, exp_data and exp_halt for every program slot
task automatic run_model();
  core_pkg::word_t regs [32];
  core_pkg::insn_t w;
  core_pkg::word_t a;
  core_pkg::word_t imm;
  for (int r = 0; r < 32; r++) begin
    regs[r] = '0;
  end
  for (int i = 0; i < prog_len; i++) begin
    w = prog[i];
    // x0 is never written so it reads zero here
    a = regs[w[19:15]];
    imm = {{20{w[31]}}, w[31:20]};
    exp_data[i] = '0;
    exp_we[i] = 1'b1;
    exp_halt[i] = 1'b0;
    if (w[6:0] == core_pkg::op_lui) begin
      exp_data[i] = {w[31:12], 12'd0};
    end else if (w[6:0] == core_pkg::op_reg_imm && w[14:12] == 3'b000) begin
      exp_data[i] = a + imm;
    end else if (w[6:0] == core_pkg::op_reg_imm && w[14:12] == 3'b010) begin
      exp_data[i] = {31'd0, $signed(a) < $signed(imm)};
    end else if (w[6:0] == core_pkg::op_reg_reg && w[14:12] == 3'b000 && w[31:25] == 7'd0) begin
      exp_data[i] = a + regs[w[24:20]];
    end else begin
      // ecall or anything unknown, no write
      exp_we[i] = 1'b0;
      exp_halt[i] = (w[6:0] == core_pkg::op_system) && (w[31:7] == 25'd0);
    end
    exp_we[i] = exp_we[i] && (w[11:7] != 5'd0);
    if (exp_we[i]) begin
      regs[w[11:7]] = exp_data[i];
    end
  end
endtask

/* tests/core_tb.sv */
module core_tb;

  localparam core_pkg::word_t reset_pc = 32'h0000_1000;
  localparam int prog_len = 40;
  // writeback is four edges behind the pc
  localparam int pipe_depth = 4;
  localparam int reset_cycles = 10;
  localparam int num_tests = 4;
  localparam int cycle_limit = (prog_len + pipe_depth + reset_cycles) * num_tests;

  logic clk;
  logic rst;
  core_pkg::word_t pc;
  core_pkg::insn_t insn;
  logic halt;
  core_pkg::word_t trace_pc;
  core_pkg::insn_t trace_insn;
  core_pkg::cycle_status_e trace_status;
  logic trace_we;
  core_pkg::reg_idx_t trace_rd;
  core_pkg::word_t trace_data;

  // program and expected writeback per slot
  core_pkg::insn_t prog [prog_len];
  core_pkg::word_t exp_data [prog_len];
  logic exp_we [prog_len];
  logic exp_halt [prog_len];

  int cycle_count = 0;
  int error_count = 0;
  int check_count = 0;
  int failed_tests = 0;

  `include "core_model.svh"

  riscv_core #(
    .reset_pc (reset_pc)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .insn         (insn),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_we     (trace_we),
    .trace_rd     (trace_rd),
    .trace_data   (trace_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // run limit from program length, pipe depth and reset per test
  initial begin
    wait (cycle_count > cycle_limit);
    $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // slot number for a pc, -1 outside the program
  function automatic int prog_index(input core_pkg::word_t addr);
    core_pkg::word_t off;
    off = addr - reset_pc;
    if (off[1:0] == 2'b00 && off < core_pkg::word_t'(prog_len * 4)) begin
      return int'(off >> 2);
    end
    return -1;
  endfunction

  // instruction memory answers for this cycle's pc
  // past the program a plain addi x0 nop
  always @(negedge clk) begin
    int at;
    at = prog_index(pc);
    if (at >= 0) begin
      insn = prog[at];
    end else begin
      insn = enc_imm(3'b000, 5'd0, 5'd0, 12'd0);
    end
  end

  task automatic check_word(input string what, input core_pkg::word_t got,
                            input core_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idx(input string what, input core_pkg::reg_idx_t got,
                           input core_pkg::reg_idx_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at time %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input core_pkg::cycle_status_e got,
                              input core_pkg::cycle_status_e exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at time %0t: trace_status is %s, expected %s", $time, got.name(),
               exp.name());
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // x1 to x4 keeps back-to-back dependencies frequent
  function automatic core_pkg::reg_idx_t pick_reg(input bit use_x0);
    return core_pkg::reg_idx_t'($urandom_range(4, use_x0 ? 0 : 1));
  endfunction

  function automatic core_pkg::insn_t random_insn(input bit use_x0, input bit use_unknown);
    core_pkg::insn_t w;
    logic [11:0] imm;
    int kind;
    // small signed immediates half the time so slti goes both ways
    if ($urandom_range(1, 0) == 0) begin
      imm = 12'($urandom_range(15, 0)) - 12'd8;
    end else begin
      imm = 12'($urandom());
    end
    kind = $urandom_range(use_unknown ? 4 : 3, 0);
    case (kind)
      0: w = enc_lui(pick_reg(use_x0), 20'($urandom()));
      1: w = enc_imm(3'b000, pick_reg(use_x0), pick_reg(use_x0), imm);
      2: w = enc_imm(3'b010, pick_reg(use_x0), pick_reg(use_x0), imm);
      3: w = enc_add(pick_reg(use_x0), pick_reg(use_x0), pick_reg(use_x0));
      default: begin
        // random bits around an opcode the core does not know
        w = $urandom();
        while (w[6:0] inside {core_pkg::op_lui, core_pkg::op_reg_imm, core_pkg::op_reg_reg,
                              core_pkg::op_system}) begin
          w[6:0] = 7'($urandom());
        end
      end
    endcase
    return w;
  endfunction

  task automatic run_test(input string name, input bit use_x0, input bit use_unknown);
    int slot;
    int idx;
    int errors_before;
    bit done;
    errors_before = error_count;
    for (int i = 0; i < prog_len - 1; i++) begin
      prog[i] = random_insn(use_x0, use_unknown);
    end
    // ecall closes every program
    prog[prog_len - 1] = enc_ecall();
    run_model();
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // slot counts cycles since rst fell
    slot = 0;
    done = 1'b0;
    while (!done) begin
      check_word("pc", pc, reset_pc + core_pkg::word_t'(4 * slot));
      if (slot < pipe_depth) begin
        // writeback still drains reset slots
        check_status(trace_status, core_pkg::cycle_reset);
        check_bit("halt", halt, 1'b0);
      end else begin
        check_status(trace_status, core_pkg::cycle_no_stall);
        check_word("trace_pc", trace_pc,
                   reset_pc + core_pkg::word_t'(4 * (slot - pipe_depth)));
        idx = prog_index(trace_pc);
        if (idx < 0) begin
          error_count++;
          $display("trace_pc %h at time %0t lies outside the program", trace_pc, $time);
        end else begin
          check_word("trace_insn", trace_insn, prog[idx]);
          check_bit("trace_we", trace_we, exp_we[idx]);
          check_bit("halt", halt, exp_halt[idx]);
          if (exp_we[idx]) begin
            check_idx("trace_rd", trace_rd, prog[idx][11:7]);
            check_word("trace_data", trace_data, exp_data[idx]);
          end
          done = (idx == prog_len - 1);
        end
      end
      slot++;
      if (!done) begin
        @(negedge clk);
      end
    end
    if (error_count != errors_before) begin
      failed_tests++;
    end
    $display("test %s: %0d errors, %s", name, error_count - errors_before,
             (error_count == errors_before) ? "passed" : "failed");
  endtask

  initial begin
    rst = 1'b1;
    insn = '0;
    void'($urandom(32'h3bec3898));
    run_test("alu_deps", 1'b0, 1'b0);
    run_test("x0_writes", 1'b1, 1'b0);
    run_test("unknown_ops", 1'b0, 1'b1);
    run_test("mixed", 1'b1, 1'b1);
    $display("tests: %0d run, %0d failed, %0d checks, %0d errors", num_tests, failed_tests,
             check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+tests
hw/core_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/retire_stage.sv
hw/riscv_core.sv
tests/core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module core_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vcore_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1
